/* rtl/hci_pkg.sv */
// Threshold and depth CSR fields are 8 bits wide, so queue depths above 255 do not fit the map
`default_nettype none

package hci_pkg;

  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned CsrAddrWidth = 4;
  localparam int unsigned ThldWidth = 8;

  // CSR byte addresses
  localparam logic [CsrAddrWidth-1:0] CmdPortAddr = 4'h0;
  localparam logic [CsrAddrWidth-1:0] RespPortAddr = 4'h4;
  localparam logic [CsrAddrWidth-1:0] ThldCtrlAddr = 4'h8;
  localparam logic [CsrAddrWidth-1:0] QueueStatusAddr = 4'hC;

  localparam logic [ThldWidth-1:0] ThldResetValue = 8'd1;

  // Command is written low dword first
  typedef struct packed {
    logic [CsrDataWidth-1:0] hi;
    logic [CsrDataWidth-1:0] lo;
  } cmd_entry_t;

  typedef logic [CsrDataWidth-1:0] resp_entry_t;

  typedef struct packed {
    logic                    req;
    logic                    is_wr;
    logic [CsrAddrWidth-1:0] addr;
    logic [CsrDataWidth-1:0] wr_data;
  } csr_req_t;

  typedef struct packed {
    logic                    rd_ack;
    logic                    rd_err;
    logic                    wr_ack;
    logic                    wr_err;
    logic [CsrDataWidth-1:0] rd_data;
  } csr_rsp_t;

endpackage

`default_nettype wire

/* rtl/hci_queue.sv */
// Caller must never push while full nor pop while empty; there is no internal guard
`default_nettype none

module hci_queue #(
  parameter type entry_t = logic [31:0],
  parameter int unsigned Depth = 8,
  parameter int unsigned ThldWidth = 8,
  localparam int unsigned DepthWidth = $clog2(Depth + 1)
) (
  input  wire logic                  aclk,
  input  wire logic                  rst_n_i,

  input  wire logic                  push_i,
  input  wire entry_t                push_data_i,

  input  wire logic                  pop_i,
  output      entry_t                head_o,

  input  wire logic [ThldWidth-1:0]  thld_i,
  output      logic [DepthWidth-1:0] depth_o,

  output      logic                  empty_o,
  output      logic                  full_o,
  output      logic                  thld_trig_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  entry_t mem [Depth];

  logic [PtrWidth-1:0]   wr_ptr;
  logic [PtrWidth-1:0]   rd_ptr;
  logic [DepthWidth-1:0] count;

  // Wrap explicitly so non power of two depths work
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge aclk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  // Simultaneous push and pop leaves count alone
  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Show-ahead head
  assign head_o  = mem[rd_ptr];
  assign depth_o = count;
  assign empty_o = (count == '0);
  assign full_o  = (count == DepthWidth'(Depth));

  assign thld_trig_o = (count != '0) && (count >= thld_i);

  // Producers upstream own the legality of every access
  assert property (@(posedge aclk) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("queue push while full");

  assert property (@(posedge aclk) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("queue pop while empty");

endmodule

`default_nettype wire

/* rtl/hci_csr.sv */
// One request per cycle with no stall; ack follows one cycle later, depths above 255 truncate
`default_nettype none

module hci_csr #(
  parameter int unsigned CmdDepthWidth = 4,
  parameter int unsigned RespDepthWidth = 4
) (
  input  wire logic                         aclk,
  input  wire logic                         rst_n_i,

  input  wire hci_pkg::csr_req_t            csr_req_i,
  output      hci_pkg::csr_rsp_t            csr_rsp_o,

  output      logic                         cmd_push_o,
  output      hci_pkg::cmd_entry_t          cmd_data_o,
  input  wire logic                         cmd_full_i,
  input  wire logic [CmdDepthWidth-1:0]     cmd_depth_i,

  output      logic                         resp_pop_o,
  input  wire hci_pkg::resp_entry_t         resp_head_i,
  input  wire logic                         resp_empty_i,
  input  wire logic [RespDepthWidth-1:0]    resp_depth_i,

  output      logic [hci_pkg::ThldWidth-1:0] cmd_thld_o,
  output      logic [hci_pkg::ThldWidth-1:0] resp_thld_o
);

  logic                              lo_pending;
  logic [hci_pkg::CsrDataWidth-1:0]  lo_word;
  logic                              lo_store;
  logic                              thld_we;
  logic                              err_d;
  logic [hci_pkg::CsrDataWidth-1:0]  rd_data_d;

  logic                              rd_ack_q;
  logic                              rd_err_q;
  logic                              wr_ack_q;
  logic                              wr_err_q;
  logic [hci_pkg::CsrDataWidth-1:0]  rd_data_q;

  // High dword comes straight from the bus on the second write
  assign cmd_data_o = '{hi: csr_req_i.wr_data, lo: lo_word};

  always_comb begin
    cmd_push_o = 1'b0;
    resp_pop_o = 1'b0;
    lo_store   = 1'b0;
    thld_we    = 1'b0;
    err_d      = 1'b0;
    rd_data_d  = '0;
    if (csr_req_i.req) begin
      if (csr_req_i.is_wr) begin
        case (csr_req_i.addr)
          hci_pkg::CmdPortAddr: begin
            if (!lo_pending) begin
              lo_store = 1'b1;
            end else if (cmd_full_i) begin
              // Low word stays pending for a retry
              err_d = 1'b1;
            end else begin
              cmd_push_o = 1'b1;
            end
          end
          hci_pkg::ThldCtrlAddr: thld_we = 1'b1;
          default:               err_d = 1'b1;
        endcase
      end else begin
        case (csr_req_i.addr)
          hci_pkg::RespPortAddr: begin
            if (resp_empty_i) begin
              err_d = 1'b1;
            end else begin
              resp_pop_o = 1'b1;
              rd_data_d  = resp_head_i;
            end
          end
          hci_pkg::ThldCtrlAddr: begin
            rd_data_d = hci_pkg::CsrDataWidth'({resp_thld_o, cmd_thld_o});
          end
          hci_pkg::QueueStatusAddr: begin
            rd_data_d = hci_pkg::CsrDataWidth'({8'(resp_depth_i), 8'(cmd_depth_i)});
          end
          default: err_d = 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
    end else begin
      rd_ack_q <= csr_req_i.req & ~csr_req_i.is_wr;
      rd_err_q <= err_d & ~csr_req_i.is_wr;
      wr_ack_q <= csr_req_i.req & csr_req_i.is_wr;
      wr_err_q <= err_d & csr_req_i.is_wr;
    end
  end

  always_ff @(posedge aclk) begin
    if (csr_req_i.req && !csr_req_i.is_wr) begin
      rd_data_q <= rd_data_d;
    end
  end

  assign csr_rsp_o = '{
    rd_ack: rd_ack_q,
    rd_err: rd_err_q,
    wr_ack: wr_ack_q,
    wr_err: wr_err_q,
    rd_data: rd_data_q
  };

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_thld_o  <= hci_pkg::ThldResetValue;
      resp_thld_o <= hci_pkg::ThldResetValue;
      lo_pending  <= 1'b0;
    end else begin
      if (thld_we) begin
        cmd_thld_o  <= csr_req_i.wr_data[7:0];
        resp_thld_o <= csr_req_i.wr_data[15:8];
      end
      if (lo_store) begin
        lo_pending <= 1'b1;
      end else if (cmd_push_o) begin
        lo_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (lo_store) begin
      lo_word <= csr_req_i.wr_data;
    end
  end

  assert property (@(posedge aclk) disable iff (!rst_n_i)
    csr_req_i.req |-> !$isunknown({csr_req_i.is_wr, csr_req_i.addr}))
    else $error("csr request with unknown address or direction");

endmodule

`default_nettype wire

/* rtl/hci_queues_top.sv */
// Controller side uses valid/ready levels; software side is the plain CSR strobe port
`default_nettype none

module hci_queues_top #(
  parameter int unsigned CmdFifoDepth = 8,
  parameter int unsigned RespFifoDepth = 8,
  localparam int unsigned CmdDepthWidth = $clog2(CmdFifoDepth + 1),
  localparam int unsigned RespDepthWidth = $clog2(RespFifoDepth + 1)
) (
  input  wire logic                      aclk,
  input  wire logic                      rst_n_i,

  input  wire hci_pkg::csr_req_t         csr_req_i,
  output      hci_pkg::csr_rsp_t         csr_rsp_o,

  // Command queue, controller reads
  output      logic                      hci_cmd_rvalid_o,
  input  wire logic                      hci_cmd_rready_i,
  output      hci_pkg::cmd_entry_t       hci_cmd_rdata_o,
  output      logic [CmdDepthWidth-1:0]  hci_cmd_depth_o,
  output      logic                      hci_cmd_full_o,
  output      logic                      hci_cmd_empty_o,
  output      logic                      hci_cmd_ready_thld_trig_o,

  // Response queue, controller writes
  input  wire logic                      hci_resp_wvalid_i,
  output      logic                      hci_resp_wready_o,
  input  wire hci_pkg::resp_entry_t      hci_resp_wdata_i,
  output      logic [RespDepthWidth-1:0] hci_resp_depth_o,
  output      logic                      hci_resp_full_o,
  output      logic                      hci_resp_empty_o,
  output      logic                      hci_resp_ready_thld_trig_o
);

  logic                          cmd_push;
  hci_pkg::cmd_entry_t           cmd_data;
  logic [hci_pkg::ThldWidth-1:0] cmd_thld;
  logic                          resp_pop;
  hci_pkg::resp_entry_t          resp_head;
  logic [hci_pkg::ThldWidth-1:0] resp_thld;

  assign hci_cmd_rvalid_o  = ~hci_cmd_empty_o;
  assign hci_resp_wready_o = ~hci_resp_full_o;

  hci_csr #(
    .CmdDepthWidth (CmdDepthWidth),
    .RespDepthWidth(RespDepthWidth)
  ) xcsr (
    .aclk        (aclk),
    .rst_n_i     (rst_n_i),
    .csr_req_i   (csr_req_i),
    .csr_rsp_o   (csr_rsp_o),
    .cmd_push_o  (cmd_push),
    .cmd_data_o  (cmd_data),
    .cmd_full_i  (hci_cmd_full_o),
    .cmd_depth_i (hci_cmd_depth_o),
    .resp_pop_o  (resp_pop),
    .resp_head_i (resp_head),
    .resp_empty_i(hci_resp_empty_o),
    .resp_depth_i(hci_resp_depth_o),
    .cmd_thld_o  (cmd_thld),
    .resp_thld_o (resp_thld)
  );

  hci_queue #(
    .entry_t  (hci_pkg::cmd_entry_t),
    .Depth    (CmdFifoDepth),
    .ThldWidth(hci_pkg::ThldWidth)
  ) xcmd_queue (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .push_i     (cmd_push),
    .push_data_i(cmd_data),
    .pop_i      (hci_cmd_rvalid_o & hci_cmd_rready_i),
    .head_o     (hci_cmd_rdata_o),
    .thld_i     (cmd_thld),
    .depth_o    (hci_cmd_depth_o),
    .empty_o    (hci_cmd_empty_o),
    .full_o     (hci_cmd_full_o),
    .thld_trig_o(hci_cmd_ready_thld_trig_o)
  );

  hci_queue #(
    .entry_t  (hci_pkg::resp_entry_t),
    .Depth    (RespFifoDepth),
    .ThldWidth(hci_pkg::ThldWidth)
  ) xresp_queue (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .push_i     (hci_resp_wvalid_i & hci_resp_wready_o),
    .push_data_i(hci_resp_wdata_i),
    .pop_i      (resp_pop),
    .head_o     (resp_head),
    .thld_i     (resp_thld),
    .depth_o    (hci_resp_depth_o),
    .empty_o    (hci_resp_empty_o),
    .full_o     (hci_resp_full_o),
    .thld_trig_o(hci_resp_ready_thld_trig_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// 100 ns clock from time 0; reset low for the first 3 rising edges, released on the third
`default_nettype none

module tb_clock_gen (
  output logic aclk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    aclk_o = 1'b0;
    forever #50 aclk_o = ~aclk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge aclk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_hci_queues.sv */
// Fixed-seed random traffic on both sides; outputs checked each falling edge against a model
`default_nettype none

module tb_hci_queues;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CmdDepth = 8;
  localparam int unsigned RespDepth = 5;
  localparam int unsigned NumOps = 2000;
  localparam int unsigned TimeoutCycles = 4 * NumOps + 100;

  logic                            aclk;
  logic                            rst_n;
  hci_pkg::csr_req_t               csr_req;
  hci_pkg::csr_rsp_t               csr_rsp;
  logic                            cmd_rvalid;
  logic                            cmd_rready;
  hci_pkg::cmd_entry_t             cmd_rdata;
  logic [$clog2(CmdDepth+1)-1:0]   cmd_depth;
  logic                            cmd_full;
  logic                            cmd_empty;
  logic                            cmd_trig;
  logic                            resp_wvalid;
  logic                            resp_wready;
  hci_pkg::resp_entry_t            resp_wdata;
  logic [$clog2(RespDepth+1)-1:0]  resp_depth;
  logic                            resp_full;
  logic                            resp_empty;
  logic                            resp_trig;

  // Model state
  hci_pkg::cmd_entry_t             cmd_q[$];
  hci_pkg::resp_entry_t            resp_q[$];
  logic [7:0]                      cmd_thld = 8'd1;
  logic [7:0]                      resp_thld = 8'd1;
  logic                            lo_pend = 1'b0;
  logic [31:0]                     lo_word;
  hci_pkg::csr_rsp_t               exp_rsp = '0;
  logic [31:0]                     rng_state = 32'd87377;
  int                              cycle_count = 0;
  int                              cmds_out = 0;
  int                              resps_read = 0;
  int                              cmd_full_seen = 0;
  int                              resp_full_seen = 0;

  tb_clock_gen xclock_gen (
    .aclk_o (aclk),
    .rst_n_o(rst_n)
  );

  hci_queues_top #(
    .CmdFifoDepth (CmdDepth),
    .RespFifoDepth(RespDepth)
  ) DUT (
    .aclk                      (aclk),
    .rst_n_i                   (rst_n),
    .csr_req_i                 (csr_req),
    .csr_rsp_o                 (csr_rsp),
    .hci_cmd_rvalid_o          (cmd_rvalid),
    .hci_cmd_rready_i          (cmd_rready),
    .hci_cmd_rdata_o           (cmd_rdata),
    .hci_cmd_depth_o           (cmd_depth),
    .hci_cmd_full_o            (cmd_full),
    .hci_cmd_empty_o           (cmd_empty),
    .hci_cmd_ready_thld_trig_o (cmd_trig),
    .hci_resp_wvalid_i         (resp_wvalid),
    .hci_resp_wready_o         (resp_wready),
    .hci_resp_wdata_i          (resp_wdata),
    .hci_resp_depth_o          (resp_depth),
    .hci_resp_full_o           (resp_full),
    .hci_resp_empty_o          (resp_empty),
    .hci_resp_ready_thld_trig_o(resp_trig)
  );

  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic exp_trig(input int depth, input logic [7:0] thld);
    return (depth != 0) && (depth >= int'(thld));
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_cmd(input hci_pkg::cmd_entry_t exp, input hci_pkg::cmd_entry_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: hci_cmd_rdata_o expected %h got %h", $time, exp, act));
    end
  endtask

  task automatic check_rsp(input hci_pkg::csr_rsp_t exp, input hci_pkg::csr_rsp_t act);
    if ({act.rd_ack, act.rd_err, act.wr_ack, act.wr_err} !==
        {exp.rd_ack, exp.rd_err, exp.wr_ack, exp.wr_err} ||
        (exp.rd_ack && act.rd_data !== exp.rd_data)) begin
      fail_run($sformatf("mismatch at %0t: csr_rsp_o expected %h got %h", $time, exp, act));
    end
  endtask

  task automatic check_status(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_outputs();
    check_rsp(exp_rsp, csr_rsp);
    check_status("hci_cmd_depth_o", 8'(cmd_q.size()), 8'(cmd_depth));
    check_status("hci_cmd_empty_o", 8'(cmd_q.size() == 0), 8'(cmd_empty));
    check_status("hci_cmd_full_o", 8'(cmd_q.size() == CmdDepth), 8'(cmd_full));
    check_status("hci_cmd_rvalid_o", 8'(cmd_q.size() != 0), 8'(cmd_rvalid));
    check_status("hci_cmd_ready_thld_trig_o", 8'(exp_trig(cmd_q.size(), cmd_thld)), 8'(cmd_trig));
    check_status("hci_resp_depth_o", 8'(resp_q.size()), 8'(resp_depth));
    check_status("hci_resp_empty_o", 8'(resp_q.size() == 0), 8'(resp_empty));
    check_status("hci_resp_full_o", 8'(resp_q.size() == RespDepth), 8'(resp_full));
    check_status("hci_resp_wready_o", 8'(resp_q.size() != RespDepth), 8'(resp_wready));
    check_status("hci_resp_ready_thld_trig_o", 8'(exp_trig(resp_q.size(), resp_thld)),
                 8'(resp_trig));
    if (cmd_q.size() != 0) begin
      check_cmd(cmd_q[0], cmd_rdata);
    end
    cmd_full_seen += (cmd_q.size() == CmdDepth);
    resp_full_seen += (resp_q.size() == RespDepth);
  endtask

  // Applies one clock edge to the model, using the inputs held during the past cycle
  task automatic model_step();
    logic cmd_pop;
    logic cmd_push;
    logic resp_pop;
    logic resp_push;
    cmd_pop = cmd_rready && (cmd_q.size() != 0);
    resp_push = resp_wvalid && (resp_q.size() < RespDepth);
    cmd_push = 1'b0;
    resp_pop = 1'b0;
    exp_rsp = '0;
    exp_rsp.rd_ack = csr_req.req && !csr_req.is_wr;
    exp_rsp.wr_ack = csr_req.req && csr_req.is_wr;
    if (exp_rsp.wr_ack) begin
      if (csr_req.addr == hci_pkg::CmdPortAddr && !lo_pend) begin
        lo_pend = 1'b1;
        lo_word = csr_req.wr_data;
      end else if (csr_req.addr == hci_pkg::CmdPortAddr) begin
        exp_rsp.wr_err = (cmd_q.size() == CmdDepth);
        cmd_push = !exp_rsp.wr_err;
      end else if (csr_req.addr == hci_pkg::ThldCtrlAddr) begin
        cmd_thld = csr_req.wr_data[7:0];
        resp_thld = csr_req.wr_data[15:8];
      end else begin
        exp_rsp.wr_err = 1'b1;
      end
    end else if (exp_rsp.rd_ack) begin
      if (csr_req.addr == hci_pkg::RespPortAddr) begin
        exp_rsp.rd_err = (resp_q.size() == 0);
        resp_pop = !exp_rsp.rd_err;
        exp_rsp.rd_data = resp_pop ? resp_q[0] : 32'h0;
      end else if (csr_req.addr == hci_pkg::ThldCtrlAddr) begin
        exp_rsp.rd_data = {16'h0, resp_thld, cmd_thld};
      end else if (csr_req.addr == hci_pkg::QueueStatusAddr) begin
        exp_rsp.rd_data = {16'h0, 8'(resp_q.size()), 8'(cmd_q.size())};
      end else begin
        exp_rsp.rd_err = 1'b1;
      end
    end
    if (cmd_pop) begin
      void'(cmd_q.pop_front());
      cmds_out++;
    end
    if (cmd_push) begin
      cmd_q.push_back({csr_req.wr_data, lo_word});
      lo_pend = 1'b0;
    end
    if (resp_pop) begin
      void'(resp_q.pop_front());
      resps_read++;
    end
    if (resp_push) begin
      resp_q.push_back(resp_wdata);
    end
  endtask

  // Traffic bias flips every 256 cycles between filling and draining the queues
  task automatic drive_random(input int idx);
    logic [31:0] r;
    hci_pkg::csr_req_t req;
    r = xorshift_next();
    req = '0;
    req.wr_data = xorshift_next();
    case (r[3:0])
      4'h4, 4'h5, 4'h6, 4'h7: req = '{1'b1, 1'b1, hci_pkg::CmdPortAddr, req.wr_data};
      4'h8, 4'h9, 4'hA:       req = '{1'b1, 1'b0, hci_pkg::RespPortAddr, '0};
      4'hB:                   req = '{1'b1, 1'b1, hci_pkg::ThldCtrlAddr, req.wr_data & 32'h0707};
      4'hC:                   req = '{1'b1, 1'b0, hci_pkg::ThldCtrlAddr, '0};
      4'hD:                   req = '{1'b1, 1'b0, hci_pkg::QueueStatusAddr, '0};
      4'hE:                   req = '{1'b1, 1'b1, hci_pkg::QueueStatusAddr, req.wr_data};
      4'hF:                   req = '{1'b1, r[11], r[15:12], req.wr_data};
      default:                req = '0;
    endcase
    // First access after reset reads the thresholds
    if (idx == 0) begin
      req = '{1'b1, 1'b0, hci_pkg::ThldCtrlAddr, '0};
    end
    csr_req <= req;
    cmd_rready <= idx[8] ? |r[6:4] : &r[7:4];
    resp_wvalid <= idx[8] ? &r[10:8] : |r[10:8];
    resp_wdata <= xorshift_next();
  endtask

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      fail_run($sformatf("timeout: run still going after %0d cycles", TimeoutCycles));
    end
  end

  initial begin
    csr_req = '0;
    cmd_rready = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata = '0;
    @(posedge rst_n);
    for (int i = 0; i < NumOps; i++) begin
      @(negedge aclk);
      check_outputs();
      @(posedge aclk);
      model_step();
      drive_random(i);
    end
    @(negedge aclk);
    check_outputs();
    if (cmds_out > 0 && resps_read > 0 && cmd_full_seen > 0 && resp_full_seen > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("random traffic never filled and drained both queues");
    end
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/hci_pkg.sv
rtl/hci_queue.sv
rtl/hci_csr.sv
rtl/hci_queues_top.sv
testbench/tb_clock_gen.sv
testbench/tb_hci_queues.sv
